// File: source/pkt_check_pkg.sv
// Shared types for the AXI-Stream packet checker
// Beat and result structs plus the verdict and FSM state encodings

package pkt_check_pkg;

    //////////////////////////////////////////////////////////////////////
    // Widths

    // Bytes carried by one stream beat
    localparam int data_bytes_max = 4;

    //////////////////////////////////////////////////////////////////////
    // Stream beat

    // Used for both received and expected beats
    typedef struct packed {
        logic [data_bytes_max*8-1:0] data;
        logic [data_bytes_max-1:0]   keep;
        logic                        last;
        logic                        dest;
    } axis_beat_t;

    //////////////////////////////////////////////////////////////////////
    // Packet verdict

    typedef enum logic [1:0] {
        MATCH,
        MISMATCH,
        UNEXPECTED
    } check_status_e;

    // One-cycle report per received packet
    typedef struct packed {
        logic          valid;
        check_status_e status;
        logic          dest;
        logic [7:0]    byte_len;
    } check_result_t;

    // Packet-level FSM states
    typedef enum logic [2:0] {
        IDLE,
        RECEIVE,
        DRAIN,
        SKIP,
        REPORT
    } check_state_e;

endpackage

// File: source/expected_store.sv
// Queues of expected beats, one circular FIFO per destination
// Host writes by the dest field; the checker pops the head of the selected queue

module expected_store #(
    parameter int NUM_DESTS   = 2,
    parameter int QUEUE_DEPTH = 16
) (
    input  logic                      axis_packet_in,
    input  logic                      arst_n,
    input  pkt_check_pkg::axis_beat_t exp_beat,
    input  logic                      exp_write,
    input  logic                      pop,
    input  logic                      pop_dest,
    output pkt_check_pkg::axis_beat_t head,
    output logic                      head_valid
);

    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    pkt_check_pkg::axis_beat_t queue_head [NUM_DESTS];
    logic [NUM_DESTS-1:0]      queue_nonempty;

    // Wrap at the queue depth, which need not be a power of two
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(QUEUE_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    for (genvar d = 0; d < NUM_DESTS; d++) begin : g_queue
        pkt_check_pkg::axis_beat_t mem [QUEUE_DEPTH];
        logic [PTR_W-1:0]          wr_ptr;
        logic [PTR_W-1:0]          rd_ptr;
        logic [CNT_W-1:0]          count;
        logic                      do_write;
        logic                      do_pop;

        assign do_write = exp_write && (int'(exp_beat.dest) == d);
        assign do_pop   = pop && (int'(pop_dest) == d);

        always_ff @(posedge axis_packet_in or negedge arst_n) begin
            if (!arst_n) begin
                wr_ptr <= '0;
                rd_ptr <= '0;
                count  <= '0;
            end else begin
                if (do_write) begin
                    wr_ptr <= next_ptr(wr_ptr);
                end
                if (do_pop) begin
                    rd_ptr <= next_ptr(rd_ptr);
                end
                if (do_write && !do_pop) begin
                    count <= count + 1'b1;
                end else if (do_pop && !do_write) begin
                    count <= count - 1'b1;
                end
            end
        end

        // Beat storage
        always_ff @(posedge axis_packet_in) begin
            if (do_write) begin
                mem[wr_ptr] <= exp_beat;
            end
        end

        assign queue_head[d]     = mem[rd_ptr];
        assign queue_nonempty[d] = (count != '0);

        // Host must not overrun a queue
        assert property (@(posedge axis_packet_in) disable iff (!arst_n)
            do_write |-> count != CNT_W'(QUEUE_DEPTH));

        // Checker FSM only pops a queue it has seen non-empty
        assert property (@(posedge axis_packet_in) disable iff (!arst_n)
            do_pop |-> count != '0);
    end

    // Head select, a dest without a queue reads as empty
    always_comb begin
        head       = queue_head[0];
        head_valid = 1'b0;
        for (int d = 0; d < NUM_DESTS; d++) begin
            if (int'(pop_dest) == d) begin
                head       = queue_head[d];
                head_valid = queue_nonempty[d];
            end
        end
    end

endmodule

// File: source/stall_timer.sv
// Counts consecutive cycles a received beat waits on an empty queue
// Flags expiry once the count reaches the runtime limit

module stall_timer #(
    parameter int STALL_WIDTH = 8
) (
    input  logic                   axis_packet_in,
    input  logic                   arst_n,
    input  logic                   enable,
    input  logic                   clear,
    input  logic [STALL_WIDTH-1:0] stall_limit,
    output logic                   expired
);

    logic [STALL_WIDTH-1:0] count;

    // Saturating counter, clear wins over enable
    always_ff @(posedge axis_packet_in or negedge arst_n) begin
        if (!arst_n) begin
            count <= '0;
        end else if (clear) begin
            count <= '0;
        end else if (enable && (count != '1)) begin
            count <= count + 1'b1;
        end
    end

    assign expired = (count >= stall_limit);

endmodule

// File: source/beat_compare.sv
// Compares a received beat with the expected head beat
// Accumulates the packet verdict and byte length until cleared after a report

module beat_compare (
    input  logic                      axis_packet_in,
    input  logic                      arst_n,
    input  pkt_check_pkg::axis_beat_t rx_beat,
    input  pkt_check_pkg::axis_beat_t head,
    input  logic                      accept,
    input  logic                      clear,
    output logic                      beat_ok,
    output logic                      exp_last,
    output logic                      packet_ok,
    output logic [7:0]                byte_len
);

    localparam int NB = pkt_check_pkg::data_bytes_max;

    logic [NB-1:0] byte_eq;
    logic [7:0]    keep_count;

    // Bytes outside keep always compare equal
    always_comb begin
        for (int b = 0; b < NB; b++) begin
            byte_eq[b] = !rx_beat.keep[b] || (rx_beat.data[b*8 +: 8] == head.data[b*8 +: 8]);
        end
    end

    assign beat_ok  = (rx_beat.keep == head.keep) && (rx_beat.last == head.last) && (&byte_eq);
    assign exp_last = head.last;

    // Bytes carried by the received beat
    always_comb begin
        keep_count = '0;
        for (int b = 0; b < NB; b++) begin
            keep_count = keep_count + 8'(rx_beat.keep[b]);
        end
    end

    always_ff @(posedge axis_packet_in or negedge arst_n) begin
        if (!arst_n) begin
            packet_ok <= 1'b1;
            byte_len  <= '0;
        end else if (clear) begin
            packet_ok <= 1'b1;
            byte_len  <= '0;
        end else if (accept) begin
            packet_ok <= packet_ok && beat_ok;
            byte_len  <= byte_len + keep_count;
        end
    end

    // Only the closing beat of a packet may be partial
    assert property (@(posedge axis_packet_in) disable iff (!arst_n)
        accept && !rx_beat.last |-> &rx_beat.keep);

endmodule

// File: source/check_fsm.sv
// Packet-level control for the checker
// Steers accept and pop, handles length mismatches and stalls, and raises the report

module check_fsm #(
    parameter int NUM_DESTS = 2
) (
    input  logic                         axis_packet_in,
    input  logic                         arst_n,
    input  logic                         rx_valid,
    input  pkt_check_pkg::axis_beat_t    rx_beat,
    input  logic                         head_valid,
    input  logic                         beat_ok,
    input  logic                         exp_last,
    input  logic                         packet_ok,
    input  logic                         expired,
    output logic                         rx_ready,
    output logic                         pop,
    output logic                         pop_dest,
    output logic                         compare_clear,
    output logic                         timer_enable,
    output logic                         timer_clear,
    output logic                         result_valid,
    output pkt_check_pkg::check_status_e result_status
);

    pkt_check_pkg::check_state_e  state;
    pkt_check_pkg::check_state_e  state_next;
    pkt_check_pkg::check_status_e verdict;
    pkt_check_pkg::check_status_e verdict_next;
    logic                         cur_dest;
    logic                         cur_dest_next;
    logic                         waiting;
    logic                         accept;
    logic                         dest_ok;

    //////////////////////////////////////////////////////////////////////
    // Handshake and strobes

    // First beat selects its own queue, later beats use the latched dest
    assign pop_dest = (state == pkt_check_pkg::IDLE) ? rx_beat.dest : cur_dest;
    assign dest_ok  = (int'(pop_dest) < NUM_DESTS);
    assign waiting  = (state == pkt_check_pkg::IDLE) || (state == pkt_check_pkg::RECEIVE);

    assign rx_ready = (waiting && head_valid) || (state == pkt_check_pkg::DRAIN);
    assign accept   = rx_valid && rx_ready;
    // One pop per compared beat; SKIP pops on its own
    assign pop      = (waiting && accept) || ((state == pkt_check_pkg::SKIP) && head_valid);

    assign timer_enable  = waiting && rx_valid && !head_valid;
    assign timer_clear   = !timer_enable;
    assign compare_clear = (state == pkt_check_pkg::REPORT);
    assign result_valid  = (state == pkt_check_pkg::REPORT);
    assign result_status = verdict;

    //////////////////////////////////////////////////////////////////////
    // Next state

    always_comb begin
        state_next    = state;
        verdict_next  = verdict;
        cur_dest_next = cur_dest;
        if ((state == pkt_check_pkg::IDLE) && rx_valid) begin
            cur_dest_next = rx_beat.dest;
        end
        case (state)
            pkt_check_pkg::IDLE, pkt_check_pkg::RECEIVE: begin
                if (accept) begin
                    if (rx_beat.last && exp_last) begin
                        state_next   = pkt_check_pkg::REPORT;
                        verdict_next = (packet_ok && beat_ok) ? pkt_check_pkg::MATCH
                                                              : pkt_check_pkg::MISMATCH;
                    end else if (rx_beat.last) begin
                        // Received packet is short
                        state_next   = pkt_check_pkg::SKIP;
                        verdict_next = pkt_check_pkg::MISMATCH;
                    end else if (exp_last) begin
                        // Received packet is long
                        state_next   = pkt_check_pkg::DRAIN;
                        verdict_next = pkt_check_pkg::MISMATCH;
                    end else begin
                        state_next = pkt_check_pkg::RECEIVE;
                    end
                end else if (rx_valid && (!dest_ok || expired)) begin
                    state_next   = pkt_check_pkg::DRAIN;
                    verdict_next = pkt_check_pkg::UNEXPECTED;
                end
            end
            pkt_check_pkg::DRAIN: begin
                if (accept && rx_beat.last) begin
                    state_next = pkt_check_pkg::REPORT;
                end
            end
            pkt_check_pkg::SKIP: begin
                if (pop && exp_last) begin
                    state_next = pkt_check_pkg::REPORT;
                end
            end
            default: begin
                state_next = pkt_check_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge axis_packet_in or negedge arst_n) begin
        if (!arst_n) begin
            state    <= pkt_check_pkg::IDLE;
            verdict  <= pkt_check_pkg::MATCH;
            cur_dest <= 1'b0;
        end else begin
            state    <= state_next;
            verdict  <= verdict_next;
            cur_dest <= cur_dest_next;
        end
    end

    // Each report is a single-cycle pulse
    assert property (@(posedge axis_packet_in) disable iff (!arst_n)
        result_valid |=> !result_valid);

endmodule

// File: source/axis_packet_checker.sv
// AXI-Stream packet checker top level
// Host loads expected beats, received packets are checked in order per destination

module axis_packet_checker #(
    parameter int NUM_DESTS   = 2,
    parameter int QUEUE_DEPTH = 16,
    parameter int STALL_WIDTH = 8
) (
    input  logic                         axis_packet_in,
    input  logic                         arst_n,
    input  pkt_check_pkg::axis_beat_t    exp_beat,
    input  logic                         exp_write,
    input  pkt_check_pkg::axis_beat_t    rx_beat,
    input  logic                         rx_valid,
    output logic                         rx_ready,
    input  logic [STALL_WIDTH-1:0]       stall_limit,
    output pkt_check_pkg::check_result_t result
);

    pkt_check_pkg::axis_beat_t    head;
    logic                         head_valid;
    logic                         pop;
    logic                         pop_dest;
    logic                         accept;
    logic                         beat_ok;
    logic                         exp_last;
    logic                         packet_ok;
    logic [7:0]                   byte_len;
    logic                         expired;
    logic                         compare_clear;
    logic                         timer_enable;
    logic                         timer_clear;
    logic                         result_valid;
    pkt_check_pkg::check_status_e result_status;

    assign accept = rx_valid && rx_ready;

    expected_store #(
        .NUM_DESTS   (NUM_DESTS),
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) expected_store_inst (
        .axis_packet_in (axis_packet_in),
        .arst_n         (arst_n),
        .exp_beat       (exp_beat),
        .exp_write      (exp_write),
        .pop            (pop),
        .pop_dest       (pop_dest),
        .head           (head),
        .head_valid     (head_valid)
    );

    stall_timer #(
        .STALL_WIDTH (STALL_WIDTH)
    ) stall_timer_inst (
        .axis_packet_in (axis_packet_in),
        .arst_n         (arst_n),
        .enable         (timer_enable),
        .clear          (timer_clear),
        .stall_limit    (stall_limit),
        .expired        (expired)
    );

    check_fsm #(
        .NUM_DESTS (NUM_DESTS)
    ) check_fsm_inst (
        .axis_packet_in (axis_packet_in),
        .arst_n         (arst_n),
        .rx_valid       (rx_valid),
        .rx_beat        (rx_beat),
        .head_valid     (head_valid),
        .beat_ok        (beat_ok),
        .exp_last       (exp_last),
        .packet_ok      (packet_ok),
        .expired        (expired),
        .rx_ready       (rx_ready),
        .pop            (pop),
        .pop_dest       (pop_dest),
        .compare_clear  (compare_clear),
        .timer_enable   (timer_enable),
        .timer_clear    (timer_clear),
        .result_valid   (result_valid),
        .result_status  (result_status)
    );

    beat_compare beat_compare_inst (
        .axis_packet_in (axis_packet_in),
        .arst_n         (arst_n),
        .rx_beat        (rx_beat),
        .head           (head),
        .accept         (accept),
        .clear          (compare_clear),
        .beat_ok        (beat_ok),
        .exp_last       (exp_last),
        .packet_ok      (packet_ok),
        .byte_len       (byte_len)
    );

    // During REPORT the select still holds the latched destination
    always_comb begin
        result.valid    = result_valid;
        result.status   = result_status;
        result.dest     = pop_dest;
        result.byte_len = byte_len;
    end

endmodule

// File: verification/checker_tb.sv
// Directed testbench for the AXI-Stream packet checker
// Loads expected beats, sends received packets and checks each result pulse

module checker_tb;

    localparam int WAIT_LIMIT = 200;

    logic                          axis_packet_in;
    logic                          arst_n;
    pkt_check_pkg::axis_beat_t     exp_beat;
    logic                          exp_write;
    pkt_check_pkg::axis_beat_t     rx_beat;
    logic                          rx_valid;
    logic                          rx_ready;
    logic [7:0]                    stall_limit;
    pkt_check_pkg::check_result_t  result;

    logic [31:0]                   lfsr_state;
    pkt_check_pkg::axis_beat_t     pkt[$];
    int                            first_wait;
    int                            errors;
    int                            tests_run;
    int                            tests_failed;

    axis_packet_checker #(
        .NUM_DESTS   (2),
        .QUEUE_DEPTH (16),
        .STALL_WIDTH (8)
    ) axis_packet_checker_inst (
        .axis_packet_in (axis_packet_in),
        .arst_n         (arst_n),
        .exp_beat       (exp_beat),
        .exp_write      (exp_write),
        .rx_beat        (rx_beat),
        .rx_valid       (rx_valid),
        .rx_ready       (rx_ready),
        .stall_limit    (stall_limit),
        .result         (result)
    );

    initial begin
        axis_packet_in = 1'b0;
        forever #5 axis_packet_in = ~axis_packet_in;
    end

    //////////////////////////////////////////////////////////////////////
    // Stimulus helpers

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic int keep_total(input pkt_check_pkg::axis_beat_t beats[$]);
        int n;
        n = 0;
        foreach (beats[i]) begin
            n += $countones(beats[i].keep);
        end
        return n;
    endfunction

    // Fills pkt with random data, full keep except on the last beat
    task automatic build_packet(input logic dest, input int nbeats, input logic [3:0] last_keep);
        pkt_check_pkg::axis_beat_t b;
        pkt.delete();
        for (int i = 0; i < nbeats; i++) begin
            b.data = random_bits(32);
            b.keep = (i == nbeats - 1) ? last_keep : 4'hf;
            b.last = (i == nbeats - 1);
            b.dest = dest;
            pkt.push_back(b);
        end
    endtask

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("*** TEST FAILED ***");
        $finish;
    endtask

    task automatic load_packet(input pkt_check_pkg::axis_beat_t beats[$]);
        foreach (beats[i]) begin
            @(negedge axis_packet_in);
            exp_beat  = beats[i];
            exp_write = 1'b1;
        end
        @(negedge axis_packet_in);
        exp_write = 1'b0;
    endtask

    // One beat per handshake, rx_ready sampled mid-cycle
    task automatic send_packet(input pkt_check_pkg::axis_beat_t beats[$]);
        int waited;
        foreach (beats[i]) begin
            @(negedge axis_packet_in);
            rx_beat  = beats[i];
            rx_valid = 1'b1;
            waited   = 0;
            #1;
            while (!rx_ready) begin
                if (waited == WAIT_LIMIT) begin
                    abort_run("timeout: rx_ready never rose for a received beat");
                end
                @(negedge axis_packet_in);
                #1;
                waited++;
            end
            if (i == 0) begin
                first_wait = waited;
            end
            @(posedge axis_packet_in);
        end
        @(negedge axis_packet_in);
        rx_valid = 1'b0;
    endtask

    task automatic expect_result(input pkt_check_pkg::check_status_e status, input logic dest,
                                 input int len);
        int waited;
        waited = 0;
        #1;
        while (!result.valid) begin
            if (waited == WAIT_LIMIT) begin
                abort_run("timeout: no result pulse after the packet was sent");
            end
            @(negedge axis_packet_in);
            #1;
            waited++;
        end
        if (result.status !== status) begin
            $display("[FAIL] result.status got %h expected %h", result.status, status);
            errors++;
        end
        if (result.dest !== dest) begin
            $display("[FAIL] result.dest got %h expected %h", result.dest, dest);
            errors++;
        end
        if (result.byte_len !== 8'(len)) begin
            $display("[FAIL] result.byte_len got %h expected %h", result.byte_len, 8'(len));
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - errors_before);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Tests

    task automatic run_basic_match();
        int e0;
        pkt_check_pkg::axis_beat_t beats[$];
        e0 = errors;
        build_packet(1'b0, 3, 4'b0111);
        beats = pkt;
        load_packet(beats);
        send_packet(beats);
        expect_result(pkt_check_pkg::MATCH, 1'b0, keep_total(beats));
        report_test("basic match", e0);
    endtask

    task automatic run_corrupt_bytes();
        int e0;
        pkt_check_pkg::axis_beat_t exp_q[$];
        pkt_check_pkg::axis_beat_t rx_q[$];
        pkt_check_pkg::axis_beat_t b;
        e0 = errors;
        // Kept byte flipped
        build_packet(1'b0, 2, 4'b0011);
        exp_q = pkt;
        rx_q  = pkt;
        b = rx_q[0];
        b.data[15:8] = b.data[15:8] ^ 8'h5a;
        rx_q[0] = b;
        load_packet(exp_q);
        send_packet(rx_q);
        expect_result(pkt_check_pkg::MISMATCH, 1'b0, keep_total(rx_q));
        // Byte outside keep flipped
        build_packet(1'b0, 2, 4'b0011);
        exp_q = pkt;
        rx_q  = pkt;
        b = rx_q[1];
        b.data[31:24] = b.data[31:24] ^ 8'ha5;
        rx_q[1] = b;
        load_packet(exp_q);
        send_packet(rx_q);
        expect_result(pkt_check_pkg::MATCH, 1'b0, keep_total(rx_q));
        report_test("corrupt bytes", e0);
    endtask

    task automatic run_short_packet();
        int e0;
        pkt_check_pkg::axis_beat_t exp_q[$];
        pkt_check_pkg::axis_beat_t rx_q[$];
        pkt_check_pkg::axis_beat_t b;
        e0 = errors;
        build_packet(1'b0, 3, 4'hf);
        exp_q = pkt;
        rx_q  = pkt[0:1];
        b = rx_q[1];
        b.last = 1'b1;
        b.keep = 4'b0011;
        rx_q[1] = b;
        load_packet(exp_q);
        send_packet(rx_q);
        expect_result(pkt_check_pkg::MISMATCH, 1'b0, keep_total(rx_q));
        // Queue must be aligned again afterwards
        build_packet(1'b0, 2, 4'hf);
        exp_q = pkt;
        load_packet(exp_q);
        send_packet(exp_q);
        expect_result(pkt_check_pkg::MATCH, 1'b0, keep_total(exp_q));
        report_test("short packet", e0);
    endtask

    task automatic run_long_packet();
        int e0;
        pkt_check_pkg::axis_beat_t exp_q[$];
        pkt_check_pkg::axis_beat_t rx_q[$];
        pkt_check_pkg::axis_beat_t b;
        e0 = errors;
        build_packet(1'b0, 2, 4'hf);
        exp_q = pkt;
        rx_q  = pkt;
        b = rx_q[1];
        b.last = 1'b0;
        rx_q[1] = b;
        b.data = random_bits(32);
        b.keep = 4'b0001;
        b.last = 1'b1;
        rx_q.push_back(b);
        load_packet(exp_q);
        send_packet(rx_q);
        expect_result(pkt_check_pkg::MISMATCH, 1'b0, keep_total(rx_q));
        report_test("long packet", e0);
    endtask

    task automatic run_stall();
        int e0;
        pkt_check_pkg::axis_beat_t beats[$];
        e0 = errors;
        // Nothing loaded for dest 1
        build_packet(1'b1, 2, 4'b0111);
        beats = pkt;
        send_packet(beats);
        if (first_wait < int'(stall_limit)) begin
            $display("rx_ready rose after %0d cycles although no beats were loaded", first_wait);
            errors++;
        end
        expect_result(pkt_check_pkg::UNEXPECTED, 1'b1, keep_total(beats));
        // Late load still before the limit
        build_packet(1'b1, 2, 4'b0111);
        beats = pkt;
        fork
            send_packet(beats);
            begin
                repeat (3) @(negedge axis_packet_in);
                load_packet(beats);
            end
        join
        expect_result(pkt_check_pkg::MATCH, 1'b1, keep_total(beats));
        report_test("stall", e0);
    endtask

    task automatic run_two_dests();
        int e0;
        pkt_check_pkg::axis_beat_t a_q[$];
        pkt_check_pkg::axis_beat_t b_q[$];
        pkt_check_pkg::axis_beat_t mix[$];
        e0 = errors;
        build_packet(1'b0, 2, 4'b0011);
        a_q = pkt;
        build_packet(1'b1, 3, 4'b0111);
        b_q = pkt;
        mix = '{a_q[0], b_q[0], a_q[1], b_q[1], b_q[2]};
        load_packet(mix);
        send_packet(a_q);
        expect_result(pkt_check_pkg::MATCH, 1'b0, keep_total(a_q));
        send_packet(b_q);
        expect_result(pkt_check_pkg::MATCH, 1'b1, keep_total(b_q));
        report_test("two destinations", e0);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Main sequence

    initial begin
        arst_n       = 1'b0;
        exp_beat     = '0;
        exp_write    = 1'b0;
        rx_beat      = '0;
        rx_valid     = 1'b0;
        stall_limit  = 8'd8;
        lfsr_state   = 32'h7dc1;
        first_wait   = 0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        repeat (10) @(negedge axis_packet_in);
        arst_n = 1'b1;

        run_basic_match();
        run_corrupt_bytes();
        run_short_packet();
        run_long_packet();
        run_stall();
        run_two_dests();

        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// File: build.f
source/pkt_check_pkg.sv
source/expected_store.sv
source/stall_timer.sv
source/beat_compare.sv
source/check_fsm.sv
source/axis_packet_checker.sv
verification/checker_tb.sv
